// ==== vid_cfg.svh ====
// video controller configuration
`ifndef VID_CFG_SVH
`define VID_CFG_SVH

// raster geometry, kept tiny for short runs
`define VID_H_VISIBLE       16      // visible pixels per line
`define VID_H_TOTAL         24      // total clocks per line
`define VID_V_VISIBLE       8       // visible lines per frame
`define VID_V_TOTAL         12      // total lines per frame

// sync ranges, start inclusive and end exclusive
`define VID_HSYNC_START     18
`define VID_HSYNC_END       21
`define VID_VSYNC_START     9
`define VID_VSYNC_END       10

// entries per playfield palette
`define VID_PAL_DEPTH       16

// bus register numbers
`define VID_REG_PFA_CTRL    4'd0    // playfield A control
`define VID_REG_PFB_CTRL    4'd1    // playfield B control
`define VID_REG_PAL_ADDR    4'd2    // palette select and index
`define VID_REG_PAL_DATA    4'd3    // palette entry, auto increment
`define VID_REG_INT_CTRL    4'd4    // mask high, clear and pending low
`define VID_REG_LINE_CMP    4'd5    // line compare value
`define VID_REG_STATUS      4'd6    // blank flags and pending

`endif

// ==== vid_pkg.sv ====
// video controller shared types
`default_nettype none

package vid_pkg;

    typedef logic [15:0] word_t;    // register word
    typedef logic [4:0]  hpos_t;    // horizontal beam count
    typedef logic [3:0]  vpos_t;    // vertical beam count
    typedef logic [3:0]  color_t;   // palette index
    typedef logic [15:0] argb_t;    // alpha[15:12] red[11:8] green[7:4] blue[3:0]
    typedef logic [11:0] rgb_t;     // red, green, blue nibbles
    typedef logic [1:0]  intr_t;    // bit 0 vblank, bit 1 line compare

    // beam position plus raster flags
    typedef struct packed {
        hpos_t h;
        vpos_t v;
        logic  de;          // visible pixel
        logic  hsync;
        logic  vsync;
        logic  h_blank;     // right of visible area
        logic  v_blank;     // below visible area
    } beam_t;

    // fields used from a playfield ctrl word
    typedef struct packed {
        logic       enable;     // ctrl bit 15
        logic [1:0] cell_shift; // cell is 2**cell_shift pixels
        logic [3:0] hscroll;    // pixels of horizontal scroll
    } pf_ctrl_t;

    // palette write port
    typedef struct packed {
        color_t index;
        argb_t  data;
    } pal_wr_t;

endpackage

`default_nettype wire

// ==== vid_timing.sv ====
// raster timing generator
`default_nettype none
`timescale 1ns/1ps

`include "vid_cfg.svh"

module vid_timing (
    output vid_pkg::beam_t  beam_o,         // beam position and raster flags
    output logic            frame_start_o,  // pulse as v enters vertical blank
    output logic            line_start_o,   // pulse at h 0 of every line
    input  wire logic       reset_i,
    input  wire logic       clk
);
    import vid_pkg::*;

    hpos_t h_cnt;   // pixel within line
    vpos_t v_cnt;   // line within frame
    logic  h_last;  // last clock of a line
    logic  v_last;  // last line of a frame

    assign h_last = (h_cnt == hpos_t'(`VID_H_TOTAL - 1));
    assign v_last = (v_cnt == vpos_t'(`VID_V_TOTAL - 1));

    // wrapping counters, one pixel per clock
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                // next line, wrap at frame end
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // flags decoded straight from the counters
    always_comb begin
        beam_o.h       = h_cnt;
        beam_o.v       = v_cnt;
        beam_o.h_blank = (h_cnt >= hpos_t'(`VID_H_VISIBLE));
        beam_o.v_blank = (v_cnt >= vpos_t'(`VID_V_VISIBLE));
        beam_o.de      = !beam_o.h_blank && !beam_o.v_blank;    // inside visible area
        beam_o.hsync   = (h_cnt >= hpos_t'(`VID_HSYNC_START))
                      && (h_cnt <  hpos_t'(`VID_HSYNC_END));
        beam_o.vsync   = (v_cnt >= vpos_t'(`VID_VSYNC_START))
                      && (v_cnt <  vpos_t'(`VID_VSYNC_END));
    end

    // first pixel clock of each line
    assign line_start_o  = (h_cnt == '0);

    // one clock per frame, start of vertical blank
    assign frame_start_o = line_start_o && (v_cnt == vpos_t'(`VID_V_VISIBLE));

endmodule

`default_nettype wire

// ==== vid_regs.sv ====
// CPU bus register file
`default_nettype none
`timescale 1ns/1ps

`include "vid_cfg.svh"

module vid_regs (
    input  wire logic               bus_cs_n_i,     // chip select, active low level
    input  wire logic               bus_rd_nwr_i,   // 1 read, 0 write
    input  wire logic [3:0]         bus_reg_num_i,  // register number
    input  wire logic               bus_bytesel_i,  // 0 high byte, 1 low byte
    input  wire logic [7:0]         bus_data_i,
    output logic      [7:0]         bus_data_o,
    output logic                    bus_intr_o,     // interrupt strobe
    input  wire vid_pkg::beam_t     beam_i,
    input  wire logic               frame_start_i,
    input  wire logic               line_start_i,
    output vid_pkg::pf_ctrl_t       pfa_ctrl_o,
    output vid_pkg::pf_ctrl_t       pfb_ctrl_o,
    output vid_pkg::pal_wr_t        pal_wr_o,       // shared palette write data
    output logic                    pal_we_a_o,     // palette A write strobe
    output logic                    pal_we_b_o,     // palette B write strobe
    input  wire logic               reset_i,
    input  wire logic               clk
);
    import vid_pkg::*;

    logic       cs_n_q;         // cs seen last clock
    logic       strobe;         // access taken this clock
    logic       commit;         // full word written this clock
    logic [7:0] hi_latch;       // even byte held for the pair
    word_t      wr_word;        // assembled write word
    word_t      rd_word;        // selected register for reads
    word_t      pfa_word;
    word_t      pfb_word;
    logic [4:0] pal_addr;       // bit 4 palette select, 3:0 index
    vpos_t      line_cmp;
    intr_t      intr_mask;
    intr_t      intr_pend;
    intr_t      intr_src;       // sources firing this clock
    intr_t      intr_clr;       // bits cleared by the CPU

    assign strobe  = cs_n_q && !bus_cs_n_i;     // falling edge of cs
    assign commit  = strobe && !bus_rd_nwr_i && bus_bytesel_i;
    assign wr_word = {hi_latch, bus_data_i};

    // palette write goes out in the commit clock
    assign pal_wr_o   = '{index: pal_addr[3:0], data: wr_word};
    assign pal_we_a_o = commit && (bus_reg_num_i == `VID_REG_PAL_DATA) && !pal_addr[4];
    assign pal_we_b_o = commit && (bus_reg_num_i == `VID_REG_PAL_DATA) && pal_addr[4];

    assign pfa_ctrl_o = '{enable: pfa_word[15], cell_shift: pfa_word[5:4],
                          hscroll: pfa_word[3:0]};
    assign pfb_ctrl_o = '{enable: pfb_word[15], cell_shift: pfb_word[5:4],
                          hscroll: pfb_word[3:0]};

    assign intr_src = {line_start_i && (beam_i.v == line_cmp), frame_start_i};
    assign intr_clr = (commit && (bus_reg_num_i == `VID_REG_INT_CTRL)) ? wr_word[1:0] : '0;

    // read mux, unmapped registers read 0
    always_comb begin
        case (bus_reg_num_i)
            `VID_REG_PFA_CTRL: rd_word = pfa_word;
            `VID_REG_PFB_CTRL: rd_word = pfb_word;
            `VID_REG_PAL_ADDR: rd_word = {11'b0, pal_addr};
            `VID_REG_INT_CTRL: rd_word = {6'b0, intr_mask, 6'b0, intr_pend};
            `VID_REG_LINE_CMP: rd_word = {12'b0, line_cmp};
            `VID_REG_STATUS:   rd_word = {12'b0, beam_i.v_blank, beam_i.h_blank, intr_pend};
            default:           rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_q     <= 1'b1;
            hi_latch   <= '0;
            bus_data_o <= '0;
            pfa_word   <= '0;
            pfb_word   <= '0;
            pal_addr   <= '0;
            line_cmp   <= '0;
            intr_mask  <= '0;
            intr_pend  <= '0;
            bus_intr_o <= 1'b0;
        end else begin
            cs_n_q <= bus_cs_n_i;
            if (strobe && !bus_rd_nwr_i && !bus_bytesel_i) begin
                hi_latch <= bus_data_i;                 // wait for odd byte
            end
            if (strobe && bus_rd_nwr_i) begin
                bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
            end
            if (commit) begin
                case (bus_reg_num_i)
                    `VID_REG_PFA_CTRL: pfa_word <= wr_word;
                    `VID_REG_PFB_CTRL: pfb_word <= wr_word;
                    `VID_REG_PAL_ADDR: pal_addr <= wr_word[4:0];
                    `VID_REG_PAL_DATA: pal_addr[3:0] <= pal_addr[3:0] + 1'b1; // wraps
                    `VID_REG_INT_CTRL: intr_mask <= wr_word[9:8];
                    `VID_REG_LINE_CMP: line_cmp <= wr_word[3:0];
                    default: ;
                endcase
            end
            // pulse only for new unmasked sources
            bus_intr_o <= |(intr_src & intr_mask & ~intr_pend);
            intr_pend  <= (intr_pend | intr_src) & ~intr_clr;
        end
    end

endmodule

`default_nettype wire

// ==== pf_gen.sv ====
// playfield pattern generator
`default_nettype none
`timescale 1ns/1ps

`include "vid_cfg.svh"

module pf_gen (
    input  wire vid_pkg::beam_t     beam_i,     // current beam position
    input  wire vid_pkg::pf_ctrl_t  ctrl_i,     // enable, scroll, cell size
    input  wire vid_pkg::pal_wr_t   pal_wr_i,   // palette write data
    input  wire logic               pal_we_i,   // palette write strobe
    output vid_pkg::argb_t          argb_o,     // pixel, one clock after beam
    input  wire logic               reset_i,
    input  wire logic               clk
);
    import vid_pkg::*;

    argb_t      pal [`VID_PAL_DEPTH];   // colour lookup table
    logic [5:0] h_sum;                  // h plus scroll, no wrap
    logic [5:0] h_cell;                 // horizontal cell number
    vpos_t      v_cell;                 // vertical cell number
    color_t     pix_index;              // palette index for this pixel

    // diagonal cell pattern from the beam
    always_comb begin
        h_sum     = 6'(beam_i.h) + 6'(ctrl_i.hscroll);
        h_cell    = h_sum >> ctrl_i.cell_shift;
        v_cell    = beam_i.v >> ctrl_i.cell_shift;
        pix_index = h_cell[3:0] + v_cell;   // low 4 bits of the sum
    end

    // palette write, cleared to black on reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `VID_PAL_DEPTH; i++) begin
                pal[i] <= '0;
            end
        end else if (pal_we_i) begin
            pal[pal_wr_i.index] <= pal_wr_i.data;
        end
    end

    // registered lookup, black when off or blanked
    always_ff @(posedge clk) begin
        if (reset_i) begin
            argb_o <= '0;
        end else if (ctrl_i.enable && beam_i.de) begin
            argb_o <= pal[pix_index];
        end else begin
            argb_o <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== vid_blend.sv ====
// playfield blend and output stage
`default_nettype none
`timescale 1ns/1ps

module vid_blend (
    input  wire vid_pkg::beam_t     beam_i,     // beam, two clocks ahead of output
    input  wire vid_pkg::argb_t     argb_a_i,   // playfield A pixel
    input  wire vid_pkg::argb_t     argb_b_i,   // playfield B pixel, alpha picks mode
    output vid_pkg::rgb_t           rgb_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o,
    input  wire logic               reset_i,
    input  wire logic               clk
);
    import vid_pkg::*;

    logic hsync_d1;         // first delay stage
    logic vsync_d1;
    logic de_d1;            // lines up with the playfield pixels
    logic [1:0] mode;       // B alpha[15:14]
    rgb_t blend_rgb;

    // mix one colour channel
    function automatic logic [3:0] blend_chan(input logic [1:0] sel,
                                              input logic [3:0] ca,
                                              input logic [3:0] cb);
        logic [4:0] sum;
        sum = {1'b0, ca} + {1'b0, cb};
        case (sel)
            2'd0:    return ca;                         // A only
            2'd1:    return sum[4] ? 4'hf : sum[3:0];   // add, clamp at 15
            2'd2:    return sum[4:1];                   // average, round down
            default: return cb;                         // B only
        endcase
    endfunction

    assign mode = argb_b_i[15:14];

    assign blend_rgb = {blend_chan(mode, argb_a_i[11:8], argb_b_i[11:8]),
                        blend_chan(mode, argb_a_i[7:4],  argb_b_i[7:4]),
                        blend_chan(mode, argb_a_i[3:0],  argb_b_i[3:0])};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_d1 <= 1'b0;
            vsync_d1 <= 1'b0;
            de_d1    <= 1'b0;
            hsync_o  <= 1'b0;
            vsync_o  <= 1'b0;
            dv_de_o  <= 1'b0;
            rgb_o    <= '0;
        end else begin
            hsync_d1 <= beam_i.hsync;
            vsync_d1 <= beam_i.vsync;
            de_d1    <= beam_i.de;
            hsync_o  <= hsync_d1;       // second stage, with colour
            vsync_o  <= vsync_d1;
            dv_de_o  <= de_d1;
            rgb_o    <= de_d1 ? blend_rgb : '0;     // black outside display
        end
    end

endmodule

`default_nettype wire

// ==== vid_top.sv ====
// two playfield video controller
`default_nettype none
`timescale 1ns/1ps

module vid_top (
    input  wire logic         bus_cs_n_i,       // chip select, active low
    input  wire logic         bus_rd_nwr_i,     // 1 read, 0 write
    input  wire logic [3:0]   bus_reg_num_i,    // register number
    input  wire logic         bus_bytesel_i,    // 0 high byte, 1 low byte
    input  wire logic [7:0]   bus_data_i,
    output logic      [7:0]   bus_data_o,
    output logic              bus_intr_o,       // CPU interrupt strobe
    output logic      [3:0]   red_o,
    output logic      [3:0]   green_o,
    output logic      [3:0]   blue_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              dv_de_o,          // display enable
    input  wire logic         reset_i,
    input  wire logic         clk               // pixel clock
);
    import vid_pkg::*;

    beam_t    beam;             // raster position and flags
    logic     frame_start;
    logic     line_start;
    pf_ctrl_t pfa_ctrl;
    pf_ctrl_t pfb_ctrl;
    pal_wr_t  pal_wr;           // shared by both palettes
    logic     pal_we_a;
    logic     pal_we_b;
    argb_t    argb_a;           // playfield pixels, one clock after beam
    argb_t    argb_b;
    rgb_t     blend_rgb;

    vid_timing vid_timing_inst (
        .beam_o(beam), .frame_start_o(frame_start), .line_start_o(line_start),
        .reset_i(reset_i), .clk(clk)
    );

    vid_regs vid_regs_inst (
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i), .bus_data_o(bus_data_o), .bus_intr_o(bus_intr_o),
        .beam_i(beam), .frame_start_i(frame_start), .line_start_i(line_start),
        .pfa_ctrl_o(pfa_ctrl), .pfb_ctrl_o(pfb_ctrl), .pal_wr_o(pal_wr),
        .pal_we_a_o(pal_we_a), .pal_we_b_o(pal_we_b),
        .reset_i(reset_i), .clk(clk)
    );

    // playfield A, base layer
    pf_gen pf_a (
        .beam_i(beam), .ctrl_i(pfa_ctrl), .pal_wr_i(pal_wr), .pal_we_i(pal_we_a),
        .argb_o(argb_a), .reset_i(reset_i), .clk(clk)
    );

    // playfield B, alpha selects blend
    pf_gen pf_b (
        .beam_i(beam), .ctrl_i(pfb_ctrl), .pal_wr_i(pal_wr), .pal_we_i(pal_we_b),
        .argb_o(argb_b), .reset_i(reset_i), .clk(clk)
    );

    vid_blend vid_blend_inst (
        .beam_i(beam), .argb_a_i(argb_a), .argb_b_i(argb_b), .rgb_o(blend_rgb),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o),
        .reset_i(reset_i), .clk(clk)
    );

    assign {red_o, green_o, blue_o} = blend_rgb;    // split colour guns

endmodule

`default_nettype wire

// ==== vid_assertions.sv ====
// video output protocol checks
`default_nettype none
`timescale 1ns/1ps

module vid_assertions (
    input  wire logic clk,
    input  wire logic reset_i,
    input  wire logic hsync_o,
    input  wire logic vsync_o,
    input  wire logic dv_de_o,
    input  wire logic bus_intr_o
);

    // outputs held quiet while reset is on
    property quiet_in_reset;
        @(posedge clk) (reset_i && $past(reset_i)) |-> (!hsync_o && !vsync_o && !dv_de_o);
    endproperty

    // no active video inside horizontal sync
    property no_de_in_hsync;
        @(posedge clk) disable iff (reset_i) !(dv_de_o && hsync_o);
    endproperty

    // interrupt strobe is a single clock
    property intr_single_cycle;
        @(posedge clk) disable iff (reset_i) bus_intr_o |=> !bus_intr_o;
    endproperty

    quiet_chk: assert property (quiet_in_reset)
        else $error("sync or de high during reset");
    de_chk: assert property (no_de_in_hsync)
        else $error("dv_de_o high during hsync");
    intr_chk: assert property (intr_single_cycle)
        else $error("bus_intr_o high for two cycles");

endmodule

bind vid_top vid_assertions vid_assertions_inst (
    .clk(clk), .reset_i(reset_i), .hsync_o(hsync_o), .vsync_o(vsync_o),
    .dv_de_o(dv_de_o), .bus_intr_o(bus_intr_o)
);

`default_nettype wire

// ==== tb_vid_top.sv ====
// video controller testbench
`default_nettype none
`timescale 1ns/1ps

`include "vid_cfg.svh"

module tb_vid_top;
    import vid_pkg::*;

    localparam int FRAME_CYCLES = `VID_H_TOTAL * `VID_V_TOTAL;    // 288
    localparam int CYCLE_LIMIT  = 8 * FRAME_CYCLES + 2000;

    // expected output of one pixel
    typedef struct packed {
        rgb_t rgb;
        logic hs;
        logic vs;
        logic de;
    } pix_t;

    logic clk = 1'b0;
    logic reset_i;
    logic bus_cs_n_i;
    logic bus_rd_nwr_i;
    logic [3:0] bus_reg_num_i;
    logic bus_bytesel_i;
    logic [7:0] bus_data_i;
    logic [7:0] bus_data_o;
    logic bus_intr_o;
    logic [3:0] red_o;
    logic [3:0] green_o;
    logic [3:0] blue_o;
    logic hsync_o;
    logic vsync_o;
    logic dv_de_o;

    // reference register state, updated on each commit
    word_t pfa_m;
    word_t pfb_m;
    argb_t pal_a [16];
    argb_t pal_b [16];
    logic  pal_sel_m;       // 0 A, 1 B
    logic [3:0] pal_idx_m;

    int   ref_h;            // model raster counters
    int   ref_v;
    pix_t pipe [2];         // two clock output latency
    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   intr_count = 0;
    int   seed = 57230;

    vid_top vid_top_inst (
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i), .bus_data_o(bus_data_o), .bus_intr_o(bus_intr_o),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o),
        .reset_i(reset_i), .clk(clk)
    );

    always #5 clk = ~clk;   // 10 ns pixel clock

    // expected pixel from raster, palette and blend rules
    function automatic pix_t ref_pixel(input int h, input int v);
        pix_t  p;
        logic  de;
        int    cs;
        int    ia;
        int    ib;
        argb_t a;
        argb_t b;
        int    ca;
        int    cb;
        int    r;
        de   = (h < `VID_H_VISIBLE) && (v < `VID_V_VISIBLE);
        p.de = de;
        p.hs = (h >= `VID_HSYNC_START) && (h < `VID_HSYNC_END);
        p.vs = (v >= `VID_VSYNC_START) && (v < `VID_VSYNC_END);
        cs = pfa_m[5:4];
        ia = (((h + pfa_m[3:0]) >> cs) + (v >> cs)) % 16;
        cs = pfb_m[5:4];
        ib = (((h + pfb_m[3:0]) >> cs) + (v >> cs)) % 16;
        a  = (pfa_m[15] && de) ? pal_a[ia] : 16'h0;
        b  = (pfb_m[15] && de) ? pal_b[ib] : 16'h0;
        p.rgb = '0;
        for (int ch = 0; ch < 3; ch++) begin
            ca = a[ch*4 +: 4];
            cb = b[ch*4 +: 4];
            case (b[15:14])
                2'd0:    r = ca;
                2'd1:    r = (ca + cb > 15) ? 15 : ca + cb;   // saturating add
                2'd2:    r = (ca + cb) / 2;
                default: r = cb;
            endcase
            p.rgb[ch*4 +: 4] = de ? r[3:0] : 4'h0;
        end
        return p;
    endfunction

    // comparator, sampled mid cycle where everything is settled
    always @(negedge clk) begin
        assert ({red_o, green_o, blue_o, hsync_o, vsync_o, dv_de_o} == pipe[1])
        else begin
            $display("FAILED %0t: pixel got %h exp %h", $time,
                     {red_o, green_o, blue_o, hsync_o, vsync_o, dv_de_o}, pipe[1]);
            errors++;
        end
        checks++;
        pipe[1] = pipe[0];
        if (reset_i) begin
            pipe[0] = '0;
            ref_h   = 0;
            ref_v   = 0;
        end else begin
            pipe[0] = ref_pixel(ref_h, ref_v);
            ref_h++;
            if (ref_h == `VID_H_TOTAL) begin
                ref_h = 0;
                ref_v = (ref_v + 1) % `VID_V_TOTAL;
            end
        end
        if (bus_intr_o) intr_count++;
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_value(input int got, input int exp, input string what);
        checks++;
        assert (got == exp)
        else begin
            $display("FAILED %0t: %s got %h exp %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // two byte write, commit on the odd byte
    task automatic write_reg(input logic [3:0] num, input word_t word);
        @(posedge clk);
        bus_cs_n_i    <= 1'b0;
        bus_rd_nwr_i  <= 1'b0;
        bus_reg_num_i <= num;
        bus_bytesel_i <= 1'b0;
        bus_data_i    <= word[15:8];
        @(posedge clk);
        bus_cs_n_i <= 1'b1;
        @(posedge clk);
        bus_cs_n_i    <= 1'b0;
        bus_bytesel_i <= 1'b1;
        bus_data_i    <= word[7:0];
        @(posedge clk);                     // commit edge
        bus_cs_n_i <= 1'b1;
        case (num)
            `VID_REG_PFA_CTRL: pfa_m = word;
            `VID_REG_PFB_CTRL: pfb_m = word;
            `VID_REG_PAL_ADDR: {pal_sel_m, pal_idx_m} = word[4:0];
            `VID_REG_PAL_DATA: begin
                if (pal_sel_m) pal_b[pal_idx_m] = word;
                else pal_a[pal_idx_m] = word;
                pal_idx_m = pal_idx_m + 1'b1;   // wraps in 4 bits
            end
            default: ;
        endcase
    endtask

    task automatic read_byte(input logic [3:0] num, input logic sel, output logic [7:0] val);
        @(posedge clk);
        bus_cs_n_i    <= 1'b0;
        bus_rd_nwr_i  <= 1'b1;
        bus_reg_num_i <= num;
        bus_bytesel_i <= sel;
        @(posedge clk);                     // access taken, data registered
        bus_cs_n_i <= 1'b1;
        @(negedge clk);
        val = bus_data_o;
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - err_before);
    endtask

    logic [7:0] rd;
    int         e0;
    word_t      w;

    initial begin
        reset_i = 1'b1;
        bus_cs_n_i = 1'b1;
        bus_rd_nwr_i = 1'b1;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i = '0;
        pfa_m = '0;
        pfb_m = '0;
        pal_sel_m = 1'b0;
        pal_idx_m = '0;
        ref_h = 0;
        ref_v = 0;
        pipe[0] = '0;
        pipe[1] = '0;
        for (int i = 0; i < 16; i++) begin
            pal_a[i] = '0;
            pal_b[i] = '0;
        end
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;

        // 1 reset state, blank frame
        e0 = errors;
        @(negedge clk);
        check_value({red_o, green_o, blue_o, hsync_o, vsync_o, dv_de_o, bus_intr_o}, 0,
                    "outputs after reset");
        repeat (FRAME_CYCLES + 2) @(posedge clk);
        end_test("reset", e0);

        // 2 playfield A alone
        e0 = errors;
        write_reg(`VID_REG_PAL_ADDR, 16'h0000);
        for (int i = 0; i < 16; i++) write_reg(`VID_REG_PAL_DATA, $random(seed));
        w = $random(seed);
        write_reg(`VID_REG_PFA_CTRL, 16'h8000 | (w & 16'h003f));
        repeat (FRAME_CYCLES + 2) @(posedge clk);
        end_test("playfield_a", e0);

        // 3 blend modes, entry i carries mode i mod 4
        e0 = errors;
        write_reg(`VID_REG_PAL_ADDR, 16'h0010);
        for (int i = 0; i < 16; i++) begin
            w = $random(seed);
            w[15:14] = 2'(i % 4);
            if (i % 4 == 1) w[11:8] = 4'hc;    // force some saturation
            write_reg(`VID_REG_PAL_DATA, w);
        end
        w = $random(seed);
        write_reg(`VID_REG_PFB_CTRL, 16'h8000 | (w & 16'h003f));
        repeat (FRAME_CYCLES + 2) @(posedge clk);
        end_test("blend", e0);

        // 4 register readback
        e0 = errors;
        write_reg(`VID_REG_PFA_CTRL, 16'h8025);
        read_byte(`VID_REG_PFA_CTRL, 1'b0, rd);
        check_value(rd, 8'h80, "PFA_CTRL high");
        read_byte(`VID_REG_PFA_CTRL, 1'b1, rd);
        check_value(rd, 8'h25, "PFA_CTRL low");
        write_reg(`VID_REG_PAL_ADDR, 16'h0007);
        read_byte(`VID_REG_PAL_ADDR, 1'b1, rd);
        check_value(rd, 8'h07, "PAL_ADDR");
        write_reg(`VID_REG_PAL_DATA, $random(seed));
        write_reg(`VID_REG_PAL_DATA, $random(seed));
        read_byte(`VID_REG_PAL_ADDR, 1'b1, rd);
        check_value(rd, 8'h09, "PAL_ADDR after increment");
        write_reg(`VID_REG_LINE_CMP, 16'h0003);
        read_byte(`VID_REG_LINE_CMP, 1'b1, rd);
        check_value(rd, 8'h03, "LINE_CMP");
        end_test("readback", e0);

        // 5 interrupts, sync to line 0 so no source meets a clear
        e0 = errors;
        for (int pass = 0; pass < 3; pass++) begin
            do begin
                @(posedge clk);             // model counters settle at negedge
            end while (!(ref_v == 0 && ref_h == 4));
            w = (pass == 1) ? 16'h0103 : 16'h0303;     // pass 1 masks line compare
            write_reg(`VID_REG_INT_CTRL, w);
            read_byte(`VID_REG_INT_CTRL, 1'b1, rd);
            check_value(rd, 8'h00, "INT_CTRL pending after clear");
            intr_count = 0;
            repeat (FRAME_CYCLES) @(posedge clk);
            check_value(intr_count, (pass == 1) ? 1 : 2, "interrupt pulses");
            read_byte(`VID_REG_INT_CTRL, 1'b0, rd);
            check_value(rd, w[9:8], "INT_CTRL mask");
            read_byte(`VID_REG_INT_CTRL, 1'b1, rd);
            check_value(rd, 8'h03, "INT_CTRL pending");
        end
        end_test("interrupts", e0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
vid_pkg.sv
vid_timing.sv
vid_regs.sv
pf_gen.sv
vid_blend.sv
vid_top.sv
vid_assertions.sv
tb_vid_top.sv

// ==== Bender.yml ====
package:
  name: vid_ctrl

sources:
  - include_dirs:
      - .
    files:
      - vid_pkg.sv
      - vid_timing.sv
      - vid_regs.sv
      - pf_gen.sv
      - vid_blend.sv
      - vid_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - vid_assertions.sv
      - tb_vid_top.sv
